//--- analog_input.mem
// op a b expected, hex; op 1 write, 2 read, 3 adc, 4 dac sum, 5 loopback, 6 pwm frame
// lanes: ch0 in bits 15:0, ch1 in bits 31:16; pwm: a channel, b 1 = align on period start
// op 0 ends the list
2 00000000 00000000 0A100001  // board id
2 00000008 00000000 00000000  // unknown hk offset
2 00200000 00000000 00000000  // unused region 2
1 00700010 12345678 00000000  // write into unused region 7
2 00700010 00000000 00000000
3 FFFC0000 00000000 20001FFF  // full scale both ways
3 7FFC8000 00000000 00003FFF  // -1 and 0
3 12371234 00000000 1B721B72  // low two bits dropped
3 A5A55A5A 00000000 36960969
4 20000FFF 3FFF1001 3FFF0000  // positive and negative limit
4 00000064 000000C8 1FFF1ED3  // 300 and 0
4 3F9C1FFF 00321FFF 20310000  // limit and -50
1 00000004 00000001 00000000  // loop on
2 00000004 00000000 00000001
5 20000FFF 3FFF1001 20001FFF
5 00000064 000000C8 0000012C
5 3F9C1FFF 00321FFF 3FCE1FFF
1 00000004 00000000 00000000  // loop off
3 12371234 00000000 1B721B72
1 00400020 001000FF 00000000  // pwm 0 duty 16, 8 dither bits
1 00400028 00FEFFFF 00000000  // pwm 2 duty 254, all dither bits
1 0040002C AB80A5A5 00000000  // pwm 3, upper byte dropped
2 00400020 00000000 001000FF
2 0040002C 00000000 0080A5A5
6 00000000 00000001 00000108
6 00000001 00000000 00000000  // never written
6 00000002 00000001 00000FF0
6 00000003 00000001 00000808
0 00000000 00000000 00000000

//--- analog_io.f
analog_pkg.sv
sys_bus_pkg.sv
sys_bus_decoder.sv
housekeeping.sv
ams_regs.sv
pwm_gen.sv
adc_frontend.sv
dac_backend.sv
analog_io_top.sv
tb_analog_io_top.sv

//--- tb_analog_io_top.sv
// analog I/O core testbench
`timescale 1ns/1ps

module tb_analog_io_top import sys_bus_pkg::*, analog_pkg::*; ();

  localparam logic [31:0] BOARD_ID  = 32'h0A10_0001;
  localparam int          MAX_WORDS = 256;   // four words per step
  localparam int          ACK_TMO   = 16;    // cycles allowed for a bus ack
  localparam int          PRD_TMO   = 600;   // a bit over two PWM periods
  localparam int          FRAME_CYC = 4096;  // 16 periods of 256 cycles
  localparam int          N_RANDOM  = 8;     // extra DAC sum steps

  logic                   adc_clk;
  logic                   arst_n;
  sys_req_t               sys_req;
  sys_rsp_t               sys_rsp;
  adc_raw_t  [N_CH-1:0]   adc_raw;   // ADC pins
  sample_t   [N_CH-1:0]   gen_dat;   // generator stream
  sample_t   [N_CH-1:0]   ctl_dat;   // controller stream
  sample_t   [N_CH-1:0]   adc_dat;
  dac_word_t [N_CH-1:0]   dac_dat;
  logic      [N_PWM-1:0]  dac_pwm;

  logic [31:0] stim [0:MAX_WORDS-1];  // op, a, b, expected per step
  integer      seed;

  analog_io_top #(.BOARD_ID (BOARD_ID)) DUT (.adc_clk (adc_clk), .arst_n_i (arst_n),
    .sys_req_i (sys_req), .sys_rsp_o (sys_rsp), .adc_dat_i (adc_raw), .gen_dat_i (gen_dat),
    .ctl_dat_i (ctl_dat), .adc_dat_o (adc_dat), .dac_dat_o (dac_dat), .dac_pwm_o (dac_pwm));

  initial adc_clk = 1'b0;
  always #50 adc_clk = ~adc_clk;  // 100 ns period

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("Fail %s expected 0x%08h actual 0x%08h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // two 14 bit words in the 16 bit lanes of a step word
  function automatic logic [31:0] pack_pair(input logic [N_CH-1:0][SAMPLE_W-1:0] w);
    return {2'b00, w[1], 2'b00, w[0]};
  endfunction

  // saturate to 14 bits, then flip the 13 magnitude bits
  function automatic logic [SAMPLE_W-1:0] expect_dac(input sample_t g, input sample_t c);
    int sum;
    sum = int'(g) + int'(c);
    if (sum > 8191)
      sum = 8191;
    else if (sum < -8192)
      sum = -8192;
    return SAMPLE_W'(sum) ^ 14'h1FFF;
  endfunction

  // one strobe, then wait for ack, sampled mid cycle
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic write, output logic [31:0] rdata);
    bit got;
    @(negedge adc_clk);
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = write;
    sys_req.ren   = !write;
    got           = 1'b0;
    for (int i = 0; i < ACK_TMO && !got; i++)
    begin
      @(negedge adc_clk);
      got         = sys_rsp.ack;
      rdata       = sys_rsp.rdata;
      sys_req.wen = 1'b0;  // strobes last one cycle
      sys_req.ren = 1'b0;
    end
    if (!got)
      abort_run($sformatf("no bus ack from address 0x%08h", addr));
    else
      check_value($sformatf("bus err at 0x%08h", addr), 32'd0, sys_rsp.err);
  endtask

  task automatic apply_streams(input logic [31:0] g, input logic [31:0] c);
    @(negedge adc_clk);
    for (int ch = 0; ch < N_CH; ch++)
    begin
      gen_dat[ch] = g[16*ch +: SAMPLE_W];
      ctl_dat[ch] = c[16*ch +: SAMPLE_W];
    end
    @(negedge adc_clk);  // past the output register
  endtask

  // align on a rising pin edge (period start) if asked, then count one frame
  task automatic count_pwm(input int ch, input logic align, output int highs);
    logic prev;
    bit   found;
    prev  = 1'b1;
    found = !align;
    for (int i = 0; i < PRD_TMO && !found; i++)
    begin
      @(negedge adc_clk);
      found = !prev && dac_pwm[ch];
      prev  = dac_pwm[ch];
    end
    if (!found)
      abort_run($sformatf("no period start seen on PWM output %0d", ch));
    highs = align ? 1 : 0;  // edge sample opens the frame
    for (int n = highs; n < FRAME_CYC; n++)
    begin
      @(negedge adc_clk);
      highs += dac_pwm[ch];
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin
    logic [31:0]          op;
    logic [31:0]          a;
    logic [31:0]          b;
    logic [31:0]          exp;
    logic [31:0]          rd;
    int                   highs;
    sample_t  [N_CH-1:0]  g;
    sample_t  [N_CH-1:0]  c;
    seed     = 35636;
    sys_req  = '0;
    adc_raw  = '0;
    gen_dat  = '0;
    ctl_dat  = '0;
    arst_n   = 1'b0;
    $readmemh("analog_input.mem", stim);
    repeat (8) @(negedge adc_clk);
    arst_n = 1'b1;

    for (int s = 0; s < MAX_WORDS/4 && stim[4*s] !== 32'd0; s++)
    begin
      op  = stim[4*s];
      a   = stim[4*s+1];
      b   = stim[4*s+2];
      exp = stim[4*s+3];
      case (op)
        32'd1 : bus_access(a, b, 1'b1, rd);             // write, no data check
        32'd2 :
        begin
          bus_access(a, '0, 1'b0, rd);
          check_value($sformatf("bus read step %0d", s), exp, rd);
        end
        32'd3 :
        begin
          @(negedge adc_clk);
          for (int ch = 0; ch < N_CH; ch++)
            adc_raw[ch] = a[16*ch +: 16];
          @(negedge adc_clk);                           // capture register
          check_value($sformatf("adc sample step %0d", s), exp, pack_pair(adc_dat));
        end
        32'd4 :
        begin
          apply_streams(a, b);
          check_value($sformatf("dac sum step %0d", s), exp, pack_pair(dac_dat));
        end
        32'd5 :
        begin
          apply_streams(a, b);
          check_value($sformatf("loopback step %0d", s), exp, pack_pair(adc_dat));
        end
        32'd6 :
        begin
          count_pwm(int'(a), b[0], highs);
          check_value($sformatf("pwm frame step %0d", s), exp, highs);
        end
        default : abort_run($sformatf("unknown operation code %h at step %0d", op, s));
      endcase
    end

    // random stream pairs, limits included by chance
    for (int r = 0; r < N_RANDOM; r++)
    begin
      for (int ch = 0; ch < N_CH; ch++)
      begin
        g[ch] = sample_t'($random(seed));
        c[ch] = sample_t'($random(seed));
      end
      apply_streams(pack_pair(g), pack_pair(c));
      check_value($sformatf("random dac sum %0d", r),
        {2'b00, expect_dac(g[1], c[1]), 2'b00, expect_dac(g[0], c[0])}, pack_pair(dac_dat));
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- analog_io_top.sv
// analog I/O core top level
`timescale 1ns/1ps

module analog_io_top import sys_bus_pkg::*; import analog_pkg::*; #(
  parameter logic [DATA_W-1:0] BOARD_ID = 32'h0A10_0001  // read at HK 0x00
)(
  input  logic                   adc_clk,     // single clock domain
  input  logic                   arst_n_i,    // async reset, active low
  input  sys_req_t               sys_req_i,   // system bus master
  output sys_rsp_t               sys_rsp_o,
  input  adc_raw_t  [N_CH-1:0]   adc_dat_i,   // ADC pins
  input  sample_t   [N_CH-1:0]   gen_dat_i,   // generator stream
  input  sample_t   [N_CH-1:0]   ctl_dat_i,   // controller stream
  output sample_t   [N_CH-1:0]   adc_dat_o,   // conditioned ADC samples
  output dac_word_t [N_CH-1:0]   dac_dat_o,   // DAC words
  output logic      [N_PWM-1:0]  dac_pwm_o    // PWM DAC pins
);

  sys_req_t [N_REGION-1:0] slv_req;   // per region requests
  sys_rsp_t [N_REGION-1:0] slv_rsp;   // per region responses
  sys_rsp_t                hk_rsp;
  sys_rsp_t                ams_rsp;
  logic                    digital_loop;
  pwm_cfg_t [N_PWM-1:0]    pwm_cfg;
  sample_t  [N_CH-1:0]     dac_sum;   // saturated sum for loopback

  //////////////////////////////
  // system bus
  //////////////////////////////

  always_comb
  begin
    slv_rsp             = '0;       // empty regions answered in the decoder
    slv_rsp[REGION_HK]  = hk_rsp;
    slv_rsp[REGION_AMS] = ams_rsp;
  end

  sys_bus_decoder i_dec (.adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .req_i (sys_req_i), .rsp_o (sys_rsp_o), .slv_req_o (slv_req), .slv_rsp_i (slv_rsp));

  housekeeping #(.BOARD_ID (BOARD_ID)) i_hk (.adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .req_i (slv_req[REGION_HK]), .rsp_o (hk_rsp), .digital_loop_o (digital_loop));

  //////////////////////////////
  // PWM outputs
  //////////////////////////////

  ams_regs i_ams (.adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .req_i (slv_req[REGION_AMS]), .rsp_o (ams_rsp), .pwm_cfg_o (pwm_cfg));

  for (genvar i = 0; i < N_PWM; i++)
  begin : g_pwm
    pwm_gen i_pwm_gen (.adc_clk (adc_clk), .arst_n_i (arst_n_i),
      .cfg_i (pwm_cfg[i]), .pwm_o (dac_pwm_o[i]));
  end

  //////////////////////////////
  // ADC and DAC paths
  //////////////////////////////

  adc_frontend i_adc (.adc_clk (adc_clk), .arst_n_i (arst_n_i), .adc_dat_i (adc_dat_i),
    .digital_loop_i (digital_loop), .loop_dat_i (dac_sum), .adc_dat_o (adc_dat_o));

  dac_backend i_dac (.adc_clk (adc_clk), .arst_n_i (arst_n_i), .gen_dat_i (gen_dat_i),
    .ctl_dat_i (ctl_dat_i), .sum_dat_o (dac_sum), .dac_dat_o (dac_dat_o));

endmodule

//--- dac_backend.sv
// DAC summing and output register
`timescale 1ns/1ps

module dac_backend import analog_pkg::*; (
  input  logic                   adc_clk,    // DAC runs on the ADC clock
  input  logic                   arst_n_i,   // async reset, active low
  input  sample_t   [N_CH-1:0]   gen_dat_i,  // generator stream
  input  sample_t   [N_CH-1:0]   ctl_dat_i,  // controller stream
  output sample_t   [N_CH-1:0]   sum_dat_o,  // saturated sum, combinational
  output dac_word_t [N_CH-1:0]   dac_dat_o   // registered DAC word
);

  localparam dac_word_t DAC_IDLE = neg_slope('0);  // word for sample 0

  logic [N_CH-1:0][SAMPLE_W:0] sum;  // 15 bit sum, one guard bit
  logic [N_CH-1:0]             ovf;  // sum does not fit 14 bits

  //////////////////////////////
  // sum and saturation
  //////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < N_CH; ch++)
    begin
      // explicit sign extension
      sum[ch] = {gen_dat_i[ch][SAMPLE_W-1], gen_dat_i[ch]}
              + {ctl_dat_i[ch][SAMPLE_W-1], ctl_dat_i[ch]};
      ovf[ch] = sum[ch][SAMPLE_W] ^ sum[ch][SAMPLE_W-1];  // top two bits differ
      if (!ovf[ch])
        sum_dat_o[ch] = sum[ch][SAMPLE_W-1:0];
      else if (sum[ch][SAMPLE_W])
        sum_dat_o[ch] = SAMPLE_MIN;   // below -8192
      else
        sum_dat_o[ch] = SAMPLE_MAX;   // above 8191
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      dac_dat_o <= {N_CH{DAC_IDLE}};  // DAC at mid scale
    else
    begin
      for (int ch = 0; ch < N_CH; ch++)
        dac_dat_o[ch] <= neg_slope(sum_dat_o[ch]);  // signed to negative slope
    end
  end

  // an overflowing sum must land on the matching limit word
  for (genvar ch = 0; ch < N_CH; ch++)
  begin : g_sat_chk
    // same operand signs and a flipped result sign mean overflow
    a_sat_word : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      (gen_dat_i[ch][SAMPLE_W-1] == ctl_dat_i[ch][SAMPLE_W-1])
        && (sum[ch][SAMPLE_W-1] != gen_dat_i[ch][SAMPLE_W-1])
      |=> dac_dat_o[ch] ==
        neg_slope($past(gen_dat_i[ch][SAMPLE_W-1]) ? SAMPLE_MIN : SAMPLE_MAX));
  end

endmodule

//--- adc_frontend.sv
// ADC capture and conversion
`timescale 1ns/1ps

module adc_frontend import analog_pkg::*; (
  input  logic                  adc_clk,         // ADC sample clock
  input  logic                  arst_n_i,        // async reset, active low
  input  adc_raw_t [N_CH-1:0]   adc_dat_i,       // raw pins, 16 bit
  input  logic                  digital_loop_i,  // select loopback
  input  sample_t  [N_CH-1:0]   loop_dat_i,      // saturated DAC sum
  output sample_t  [N_CH-1:0]   adc_dat_o        // two's complement samples
);

  logic [N_CH-1:0][SAMPLE_W-1:0] adc_q;  // captured top 14 bits

  //////////////////////////////
  // capture
  //////////////////////////////

  // low two bits belong to a 16 bit converter, dropped here
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int ch = 0; ch < N_CH; ch++)
        adc_q[ch] <= neg_slope('0);   // raw code of sample 0
    end
    else
    begin
      for (int ch = 0; ch < N_CH; ch++)
        adc_q[ch] <= adc_dat_i[ch][ADC_W-1 -: SAMPLE_W];
    end
  end

  //////////////////////////////
  // conversion and loop select
  //////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < N_CH; ch++)
    begin
      if (digital_loop_i)
        adc_dat_o[ch] = loop_dat_i[ch];         // DAC word straight back, no delay
      else
        adc_dat_o[ch] = neg_slope(adc_q[ch]);   // negative slope to signed
    end
  end

endmodule

//--- pwm_gen.sv
// dithered PWM output
`timescale 1ns/1ps

module pwm_gen import analog_pkg::*; (
  input  logic     adc_clk,   // PWM runs on the ADC clock
  input  logic     arst_n_i,  // async reset, active low
  input  pwm_cfg_t cfg_i,     // live register value
  output logic     pwm_o      // PWM pin
);

  localparam int FRM_W = $clog2(PWM_FRAME);  // period index bits

  logic [PWM_DUTY_W-1:0] cnt;         // position in the 256 cycle period
  logic [FRM_W-1:0]      prd;         // period inside the 16 period frame
  pwm_cfg_t              cfg_q;       // config used for this period
  logic                  period_end;  // last cycle of a period
  logic [PWM_DUTY_W:0]   high_len;    // high cycles this period, up to 256

  assign period_end = &cnt;

  // base duty plus one when this period's dither bit is set
  assign high_len = {1'b0, cfg_q.duty} + {{PWM_DUTY_W{1'b0}}, cfg_q.dither[prd]};

  //////////////////////////////
  // counters and output
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cnt   <= '0;
      prd   <= '0;
      cfg_q <= '0;     // duty 0 keeps the pin low
      pwm_o <= 1'b0;
    end
    else
    begin
      cnt   <= cnt + 1'b1;                      // wraps every 256
      pwm_o <= ({1'b0, cnt} < high_len);        // high at period start
      if (period_end)
      begin
        prd   <= prd + 1'b1;                    // next period of frame
        cfg_q <= cfg_i;                         // new setup only at the boundary
      end
    end
  end

endmodule

//--- ams_regs.sv
// PWM configuration registers
`timescale 1ns/1ps

module ams_regs import sys_bus_pkg::*; import analog_pkg::*; (
  input  logic                  adc_clk,    // bus clock
  input  logic                  arst_n_i,   // async reset, active low
  input  sys_req_t              req_i,      // gated request
  output sys_rsp_t              rsp_o,      // registered response
  output pwm_cfg_t [N_PWM-1:0]  pwm_cfg_o   // one word per PWM output
);

  localparam int IDX_W = $clog2(N_PWM);        // register index bits
  localparam int CFG_W = $bits(pwm_cfg_t);     // 24 bit payload

  // first PWM register, the rest follow at 4 byte steps
  localparam logic [REGION_LSB-1:0] OFS_PWM = 'h20;

  logic [REGION_LSB-1:0] ofs;
  logic                  pwm_hit;   // offset inside 0x20..0x2c, word aligned
  logic [IDX_W-1:0]      pwm_idx;   // which of the four
  logic [DATA_W-1:0]     rdata;
  logic                  ack;

  assign ofs     = req_i.addr[REGION_LSB-1:0];
  assign pwm_idx = ofs[2 +: IDX_W];
  assign pwm_hit = (ofs[REGION_LSB-1:IDX_W+2] == OFS_PWM[REGION_LSB-1:IDX_W+2])
                && (ofs[1:0] == 2'b00);

  //////////////////////////////
  // config storage
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pwm_cfg_o <= '0;                                     // all outputs idle
    else if (req_i.wen && pwm_hit)
      pwm_cfg_o[pwm_idx] <= req_i.wdata[CFG_W-1:0];       // upper byte ignored
  end

  //////////////////////////////
  // bus response
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack   <= 1'b0;
      rdata <= '0;
    end
    else
    begin
      ack <= req_i.wen | req_i.ren;
      if (req_i.ren)
      begin
        rdata <= '0;                                        // unknown offsets read 0
        if (pwm_hit)
          rdata[CFG_W-1:0] <= pwm_cfg_o[pwm_idx];
      end
    end
  end

  assign rsp_o = '{rdata: rdata, ack: ack, err: 1'b0};

  // ack is a single pulse per strobe
  a_ack_pulse : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    rsp_o.ack |=> !rsp_o.ack);

endmodule

//--- housekeeping.sv
// housekeeping registers
`timescale 1ns/1ps

module housekeeping import sys_bus_pkg::*; #(
  parameter logic [DATA_W-1:0] BOARD_ID = 32'h0A10_0001  // identification word
)(
  input  logic     adc_clk,         // bus clock
  input  logic     arst_n_i,        // async reset, active low
  input  sys_req_t req_i,           // gated request
  output sys_rsp_t rsp_o,           // registered response
  output logic     digital_loop_o   // DAC words back into ADC path
);

  // register offsets inside the region
  localparam logic [REGION_LSB-1:0] OFS_ID   = 'h00;  // read only
  localparam logic [REGION_LSB-1:0] OFS_LOOP = 'h04;  // loop bit 0

  logic [REGION_LSB-1:0] ofs;    // offset part of address
  logic [DATA_W-1:0]     rdata;  // read data
  logic                  ack;    // one cycle after strobe

  assign ofs = req_i.addr[REGION_LSB-1:0];

  //////////////////////////////
  // loop control
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      digital_loop_o <= 1'b0;              // normal ADC path
    else if (req_i.wen && (ofs == OFS_LOOP))
      digital_loop_o <= req_i.wdata[0];
  end

  //////////////////////////////
  // bus response
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack   <= 1'b0;
      rdata <= '0;
    end
    else
    begin
      ack <= req_i.wen | req_i.ren;  // writes to unknown offsets ack too
      if (req_i.ren)
      begin
        case (ofs)
          OFS_ID   : rdata <= BOARD_ID;
          OFS_LOOP : rdata <= {{(DATA_W-1){1'b0}}, digital_loop_o};
          default  : rdata <= '0;     // unknown offset reads zero
        endcase
      end
    end
  end

  assign rsp_o = '{rdata: rdata, ack: ack, err: 1'b0};

endmodule

//--- sys_bus_decoder.sv
// system bus region decoder
`timescale 1ns/1ps

module sys_bus_decoder import sys_bus_pkg::*; (
  input  logic                     adc_clk,    // bus clock
  input  logic                     arst_n_i,   // async reset, active low
  input  sys_req_t                 req_i,      // from master
  output sys_rsp_t                 rsp_o,      // to master
  output sys_req_t [N_REGION-1:0]  slv_req_o,  // per region request
  input  sys_rsp_t [N_REGION-1:0]  slv_rsp_i   // per region response
);

  // regions that hold a real slave
  localparam logic [N_REGION-1:0] MAPPED = (N_REGION'(1) << REGION_HK)
                                         | (N_REGION'(1) << REGION_AMS);

  logic [REGION_W-1:0]    region;   // addressed region
  logic [N_REGION-1:0]    cs;       // one-hot region select
  sys_rsp_t [N_REGION-1:0] rsp_arr; // responses incl. empty regions

  assign region = req_i.addr[REGION_LSB +: REGION_W];  // addr[22:20]
  assign cs     = N_REGION'(1) << region;

  //////////////////////////////
  // strobe fan-out
  //////////////////////////////

  always_comb
  begin
    for (int r = 0; r < N_REGION; r++)
    begin
      slv_req_o[r]     = req_i;               // addr and data go everywhere
      slv_req_o[r].wen = req_i.wen & cs[r];   // strobes only to the selected one
      slv_req_o[r].ren = req_i.ren & cs[r];
    end
  end

  //////////////////////////////
  // response mux
  //////////////////////////////

  always_comb
  begin
    for (int r = 0; r < N_REGION; r++)
    begin
      if (MAPPED[r])
        rsp_arr[r] = slv_rsp_i[r];
      else
        rsp_arr[r] = RSP_UNUSED;  // immediate ack, reads zero
    end
  end

  assign rsp_o = rsp_arr[region];  // master sees only the addressed region

  // master never raises both strobes
  a_strobe_excl : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(req_i.wen && req_i.ren));

endmodule

//--- sys_bus_pkg.sv
// system bus definitions
package sys_bus_pkg;

  //////////////////////////////
  // bus geometry
  //////////////////////////////

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int N_REGION   = 8;                 // regions on the bus
  localparam int REGION_W   = $clog2(N_REGION);  // 3 bit region field
  localparam int REGION_LSB = 20;                // region field is addr[22:20]

  // mapped regions
  localparam int REGION_HK  = 0;  // housekeeping
  localparam int REGION_AMS = 4;  // analog mixed signals

  // master to slave
  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // byte address
    logic [DATA_W-1:0] wdata;  // write data
    logic              wen;    // write strobe, single cycle
    logic              ren;    // read strobe, single cycle
  } sys_req_t;

  // slave to master
  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // read data, valid with ack
    logic              ack;    // transfer done
    logic              err;    // never set here
  } sys_rsp_t;

  // answer of an empty region
  localparam sys_rsp_t RSP_UNUSED = '{rdata: '0, ack: 1'b1, err: 1'b0};

endpackage

//--- analog_pkg.sv
// analog path definitions
package analog_pkg;

  //////////////////////////////
  // widths and counts
  //////////////////////////////

  localparam int ADC_W      = 16;  // raw ADC pin word
  localparam int SAMPLE_W   = 14;  // signed sample width
  localparam int N_CH       = 2;   // analog channels
  localparam int N_PWM      = 4;   // PWM outputs
  localparam int PWM_DUTY_W = 8;   // 256 cycles per period
  localparam int PWM_FRAME  = 16;  // periods per dither frame

  typedef logic        [ADC_W-1:0]    adc_raw_t;   // straight from the ADC pins
  typedef logic signed [SAMPLE_W-1:0] sample_t;    // two's complement
  typedef logic        [SAMPLE_W-1:0] dac_word_t;  // negative-slope offset binary

  // saturation limits
  localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};  // +8191
  localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};  // -8192

  // one PWM channel setup, duty in the upper byte
  typedef struct packed {
    logic [PWM_DUTY_W-1:0] duty;    // base high cycles per period
    logic [PWM_FRAME-1:0]  dither;  // bit k adds a cycle in period k
  } pwm_cfg_t;

  // negative-slope offset binary <-> two's complement
  // same bit operation both ways, so it is its own inverse
  function automatic logic [SAMPLE_W-1:0] neg_slope(input logic [SAMPLE_W-1:0] w);
    return {w[SAMPLE_W-1], ~w[SAMPLE_W-2:0]};  // keep sign, flip the rest
  endfunction

endpackage
